/* battle_ctrl.f */
hdl/battle_pkg.sv
hdl/uart_rx.sv
hdl/key_decode.sv
hdl/timing_bar.sv
hdl/battle_fsm.sv
hdl/uart_tx.sv
hdl/battle_top.sv
test/tb_battle.sv

/* Bender.yml */
package:
  name: battle_ctrl

sources:
  - files:
      - hdl/battle_pkg.sv
      - hdl/uart_rx.sv
      - hdl/key_decode.sv
      - hdl/timing_bar.sv
      - hdl/battle_fsm.sv
      - hdl/uart_tx.sv
      - hdl/battle_top.sv
  - target: test
    files:
      - test/tb_battle.sv

/* test/tb_battle.sv */
`timescale 1ns/10ps

module tb_battle
    import battle_pkg::*;
();

    localparam int BIT_CLKS    = 16;
    localparam int STEP_CLKS   = 64;
    localparam int DEFEND_CLKS = 2000;
    localparam int NUM_KEYS    = 120;

    logic    clk;
    logic    cursor_position_rst;
    logic    i_rx;
    logic    o_tx;
    phase_t  o_phase;
    cursor_t o_cursor;
    hp_t     o_monster_hp;
    coord_t  o_bar_x;

    // reference model state
    phase_t  exp_phase;
    cursor_t exp_cursor;
    hp_t     exp_hp;
    int      seed_ret;
    int      step;

    battle_top #(
        .CLKS_PER_BIT   (BIT_CLKS),
        .BAR_STEP_CYCLES(STEP_CLKS),
        .DEFEND_CYCLES  (DEFEND_CLKS)
    ) i_dut (
        .clk                (clk),
        .cursor_position_rst(cursor_position_rst),
        .i_rx               (i_rx),
        .o_tx               (o_tx),
        .o_phase            (o_phase),
        .o_cursor           (o_cursor),
        .o_monster_hp       (o_monster_hp),
        .o_bar_x            (o_bar_x)
    );

    always #10 clk = ~clk;

    //////////////////////////////////////////////////
    // failure reporting and checks
    //////////////////////////////////////////////////

    task automatic stop_with_fail();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s (time %0t)", what, $time);
        stop_with_fail();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR time %0t %s got %0h expected %0h", $time, name, got, exp);
            stop_with_fail();
        end
    endtask

    //////////////////////////////////////////////////
    // reference rules
    //////////////////////////////////////////////////

    function automatic bit is_key(input byte_t b);
        return b == KEY_ENTER || b == KEY_SPACE || b == KEY_W ||
               b == KEY_A || b == KEY_S || b == KEY_D;
    endfunction

    // innermost zone wins
    function automatic hp_t zone_damage(input coord_t x);
        if (x >= 305 && x <= 325) begin
            return 16'd100;
        end else if (x >= 220 && x <= 395) begin
            return 16'd50;
        end else if (x >= 160 && x <= 455) begin
            return 16'd10;
        end else if (x >= 115 && x <= 500) begin
            return 16'd5;
        end
        return 16'd0;
    endfunction

    // last position before a step would pass the screen edge
    function automatic int bar_end_x();
        int x;
        x = 15;
        while (x + 8 <= 640) begin
            x = x + 8;
        end
        return x;
    endfunction

    function automatic byte_t pick_byte();
        byte_t b;
        case ($urandom_range(0, 7))
            0, 6:    b = KEY_ENTER;
            1:       b = KEY_SPACE;
            2:       b = KEY_W;
            3:       b = KEY_A;
            4:       b = KEY_S;
            5:       b = KEY_D;
            default: begin
                b = byte_t'($urandom);
                // all key codes are below 8'h80
                if (is_key(b)) begin
                    b[7] = 1'b1;
                end
            end
        endcase
        return b;
    endfunction

    // home and menu rules only, attack is handled by watch_attack
    task automatic apply_key(input byte_t b);
        case (exp_phase)
            PH_HOME: begin
                if (b == KEY_ENTER) begin
                    exp_phase  = PH_MENU;
                    exp_cursor = 2'd0;
                end
            end
            PH_MENU: begin
                if (b == KEY_A && exp_cursor != 2'd0) begin
                    exp_cursor = exp_cursor - 2'd1;
                end else if (b == KEY_D && exp_cursor != 2'd3) begin
                    exp_cursor = exp_cursor + 2'd1;
                end else if (b == KEY_ENTER && exp_cursor == 2'd0) begin
                    exp_phase = PH_ATTACK;
                end else if (b == KEY_ENTER && exp_cursor == 2'd3) begin
                    exp_phase = PH_HOME;
                    exp_hp    = 16'd200;
                end
            end
            default: ;
        endcase
    endtask

    //////////////////////////////////////////////////
    // serial driver and echo monitor
    //////////////////////////////////////////////////

    task automatic send_frame(input byte_t b);
        int i;
        i_rx = 1'b0;
        repeat (BIT_CLKS) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            i_rx = b[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
        i_rx = 1'b1;
        repeat (BIT_CLKS) @(negedge clk);
    endtask

    task automatic capture_echo(input byte_t b);
        int    n;
        int    i;
        byte_t got;
        n = 0;
        while (o_tx !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > 25 * BIT_CLKS) begin
                stop_on_timeout("no echo start bit seen on o_tx");
            end
        end
        // sample in the middle of each bit
        repeat (BIT_CLKS / 2) @(negedge clk);
        check_value("o_tx start bit", o_tx, 1'b0);
        for (i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            got[i] = o_tx;
        end
        check_value("o_tx echo byte", got, b);
        repeat (BIT_CLKS) @(negedge clk);
        check_value("o_tx stop bit", o_tx, 1'b1);
    endtask

    task automatic expect_silence(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("o_tx idle", o_tx, 1'b1);
        end
    endtask

    //////////////////////////////////////////////////
    // phase watchers
    //////////////////////////////////////////////////

    task automatic wait_for_state();
        int n;
        n = 0;
        while (o_phase !== exp_phase || o_cursor !== exp_cursor) begin
            @(negedge clk);
            n++;
            if (n > 300) begin
                stop_on_timeout("phase and cursor never reached the model values");
            end
        end
        check_value("o_monster_hp", o_monster_hp, exp_hp);
    endtask

    task automatic time_defend();
        int n;
        n = 0;
        while (o_phase == PH_DEFEND) begin
            @(negedge clk);
            n++;
            if (n > DEFEND_CLKS + 100) begin
                stop_on_timeout("defend phase never ended");
            end
        end
        check_value("defend cycles", n, DEFEND_CLKS);
        exp_phase  = PH_MENU;
        exp_cursor = 2'd0;
        check_value("o_phase", o_phase, exp_phase);
        check_value("o_cursor", o_cursor, exp_cursor);
    endtask

    // last bar value seen before the phase leaves attack
    task automatic watch_attack(input bit hit);
        int     n;
        coord_t last_bar;
        hp_t    dmg;
        n = 0;
        last_bar = o_bar_x;
        while (o_phase == PH_ATTACK) begin
            last_bar = o_bar_x;
            @(negedge clk);
            n++;
            if (n > 82 * STEP_CLKS) begin
                stop_on_timeout("phase never left attack");
            end
        end
        if (hit) begin
            dmg = zone_damage(last_bar);
            if (exp_hp <= dmg) begin
                exp_phase = PH_HOME;
                exp_hp    = 16'd200;
            end else begin
                exp_phase = PH_DEFEND;
                exp_hp    = exp_hp - dmg;
            end
        end else begin
            check_value("o_bar_x at overtime", last_bar, bar_end_x());
            exp_phase = PH_DEFEND;
        end
        check_value("o_phase", o_phase, exp_phase);
        check_value("o_monster_hp", o_monster_hp, exp_hp);
        if (exp_phase == PH_DEFEND) begin
            time_defend();
        end
    endtask

    task automatic run_attack(input bit hit);
        int delay;
        if (hit) begin
            // space must land well before the bar runs off screen
            delay = $urandom_range(0, 68 * STEP_CLKS);
            repeat (delay) @(negedge clk);
            fork
                send_frame(KEY_SPACE);
                capture_echo(KEY_SPACE);
                watch_attack(1'b1);
            join
        end else begin
            watch_attack(1'b0);
        end
    endtask

    task automatic press_key(input byte_t b);
        fork
            send_frame(b);
            if (is_key(b)) capture_echo(b);
            else expect_silence(10 * BIT_CLKS + 60);
        join
        apply_key(b);
        wait_for_state();
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        clk                 = 1'b0;
        cursor_position_rst = 1'b1;
        i_rx                = 1'b1;
        seed_ret            = $urandom(32'h6a9f220f);
        repeat (4) @(negedge clk);
        cursor_position_rst = 1'b0;
        @(negedge clk);

        check_value("o_tx", o_tx, 1'b1);
        check_value("o_phase", o_phase, PH_HOME);
        check_value("o_cursor", o_cursor, 2'd0);
        check_value("o_monster_hp", o_monster_hp, 16'd200);
        check_value("o_bar_x", o_bar_x, 16'd15);
        exp_phase  = PH_HOME;
        exp_cursor = 2'd0;
        exp_hp     = 16'd200;

        for (step = 0; step < NUM_KEYS; step++) begin
            repeat ($urandom_range(0, 40)) @(negedge clk);
            press_key(pick_byte());
            // mostly hits, sometimes let the bar run out
            if (exp_phase == PH_ATTACK) begin
                run_attack($urandom_range(0, 3) != 0);
            end
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

/* hdl/battle_top.sv */
`timescale 1ns/10ps

module battle_top
    import battle_pkg::*;
#(
    parameter int CLKS_PER_BIT    = 434,
    parameter int BAR_STEP_CYCLES = 1600000,
    parameter int BAR_VELOCITY    = 8,
    parameter int BAR_START_X     = 15,
    parameter int DEFEND_CYCLES   = 300000000
) (
    input  logic    clk,
    input  logic    cursor_position_rst,
    input  logic    i_rx,
    output logic    o_tx,
    output phase_t  o_phase,
    output cursor_t o_cursor,
    output hp_t     o_monster_hp,
    output coord_t  o_bar_x
);

    byte_t rx_byte;
    logic  rx_valid;
    key_t  keys;
    byte_t echo_byte;
    logic  echo_send;
    logic  bar_restart;
    logic  bar_overtime;

    //////////////////////////////////////////////////
    // serial in, decode
    //////////////////////////////////////////////////

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) i_uart_rx (
        .clk                (clk),
        .cursor_position_rst(cursor_position_rst),
        .i_rx               (i_rx),
        .o_byte             (rx_byte),
        .o_byte_valid       (rx_valid)
    );

    key_decode i_key_decode (
        .clk                (clk),
        .cursor_position_rst(cursor_position_rst),
        .i_byte             (rx_byte),
        .i_byte_valid       (rx_valid),
        .o_keys             (keys),
        .o_echo             (echo_byte),
        .o_echo_send        (echo_send)
    );

    //////////////////////////////////////////////////
    // game and bar, echo out
    //////////////////////////////////////////////////

    battle_fsm #(
        .DEFEND_CYCLES(DEFEND_CYCLES)
    ) i_battle_fsm (
        .clk                (clk),
        .cursor_position_rst(cursor_position_rst),
        .i_keys             (keys),
        .i_bar_x            (o_bar_x),
        .i_overtime         (bar_overtime),
        .o_bar_restart      (bar_restart),
        .o_phase            (o_phase),
        .o_cursor           (o_cursor),
        .o_monster_hp       (o_monster_hp)
    );

    timing_bar #(
        .BAR_STEP_CYCLES(BAR_STEP_CYCLES),
        .BAR_VELOCITY   (BAR_VELOCITY),
        .BAR_START_X    (BAR_START_X)
    ) i_timing_bar (
        .clk                (clk),
        .cursor_position_rst(cursor_position_rst),
        .i_restart          (bar_restart),
        .o_bar_x            (o_bar_x),
        .o_overtime         (bar_overtime)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) i_uart_tx (
        .clk                (clk),
        .cursor_position_rst(cursor_position_rst),
        .i_byte             (echo_byte),
        .i_send             (echo_send),
        .o_tx               (o_tx)
    );

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx
    import battle_pkg::*;
#(
    parameter int CLKS_PER_BIT = 434
) (
    input  logic  clk,
    input  logic  cursor_position_rst,
    input  byte_t i_byte,
    input  logic  i_send,
    output logic  o_tx
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    logic             busy;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bits_left;
    logic [8:0]       shift_q;

    // start bit goes out on load, then data and stop from shift_q
    always_ff @(posedge clk) begin
        if (cursor_position_rst) begin
            o_tx      <= 1'b1;
            busy      <= 1'b0;
            clk_cnt   <= '0;
            bits_left <= '0;
        end else if (!busy) begin
            if (i_send) begin
                busy      <= 1'b1;
                o_tx      <= 1'b0;
                clk_cnt   <= '0;
                bits_left <= 4'd9;
            end
        end else if (clk_cnt == FULL_BIT) begin
            clk_cnt <= '0;
            if (bits_left == 4'd0) begin
                busy <= 1'b0;
            end else begin
                o_tx      <= shift_q[0];
                bits_left <= bits_left - 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && i_send) begin
            shift_q <= {1'b1, i_byte};
        end else if (busy && clk_cnt == FULL_BIT) begin
            shift_q <= {1'b1, shift_q[8:1]};
        end
    end

    // echo requests are spaced by the receiver, so an overlap means a lost byte
    a_no_send_while_busy: assert property (
        @(posedge clk) disable iff (cursor_position_rst)
        !(i_send && busy)
    ) else $error("uart_tx: send strobe dropped while a frame is going out");

endmodule

/* hdl/battle_fsm.sv */
`timescale 1ns/10ps

module battle_fsm
    import battle_pkg::*;
#(
    parameter int DEFEND_CYCLES = 300000000
) (
    input  logic    clk,
    input  logic    cursor_position_rst,
    input  key_t    i_keys,
    input  coord_t  i_bar_x,
    input  logic    i_overtime,
    output logic    o_bar_restart,
    output phase_t  o_phase,
    output cursor_t o_cursor,
    output hp_t     o_monster_hp
);

    localparam int WAIT_W = $clog2(DEFEND_CYCLES + 1);
    localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(DEFEND_CYCLES - 1);

    localparam cursor_t CUR_FIGHT = 2'd0;
    localparam cursor_t CUR_MERCY = 2'd3;

    logic [WAIT_W-1:0] wait_cnt;
    hp_t               damage;

    //////////////////////////////////////////////////
    // zone scoring
    //////////////////////////////////////////////////

    always_comb begin
        if (i_bar_x >= GREEN_LO && i_bar_x <= GREEN_HI) begin
            damage = GREEN_DMG;
        end else if (i_bar_x >= YELLOW_LO && i_bar_x <= YELLOW_HI) begin
            damage = YELLOW_DMG;
        end else if (i_bar_x >= ORANGE_LO && i_bar_x <= ORANGE_HI) begin
            damage = ORANGE_DMG;
        end else if (i_bar_x >= BLUE_LO && i_bar_x <= BLUE_HI) begin
            damage = BLUE_DMG;
        end else begin
            damage = '0;
        end
    end

    //////////////////////////////////////////////////
    // phase machine
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (cursor_position_rst) begin
            o_phase       <= PH_HOME;
            o_cursor      <= CUR_FIGHT;
            o_monster_hp  <= MONSTER_HP_MAX;
            o_bar_restart <= 1'b0;
            wait_cnt      <= '0;
        end else begin
            o_bar_restart <= 1'b0;
            wait_cnt      <= '0;
            case (o_phase)
                PH_HOME: begin
                    if (i_keys.enter) begin
                        o_phase  <= PH_MENU;
                        o_cursor <= CUR_FIGHT;
                    end
                end
                PH_MENU: begin
                    if (i_keys.a && o_cursor != CUR_FIGHT) begin
                        o_cursor <= o_cursor - 1'b1;
                    end else if (i_keys.d && o_cursor != CUR_MERCY) begin
                        o_cursor <= o_cursor + 1'b1;
                    end else if (i_keys.enter && o_cursor == CUR_FIGHT) begin
                        o_phase       <= PH_ATTACK;
                        o_bar_restart <= 1'b1;
                    end else if (i_keys.enter && o_cursor == CUR_MERCY) begin
                        o_phase      <= PH_HOME;
                        o_monster_hp <= MONSTER_HP_MAX;
                    end
                end
                PH_ATTACK: begin
                    // a killing blow ends the battle
                    if (i_keys.space) begin
                        if (o_monster_hp <= damage) begin
                            o_phase      <= PH_HOME;
                            o_monster_hp <= MONSTER_HP_MAX;
                        end else begin
                            o_phase      <= PH_DEFEND;
                            o_monster_hp <= o_monster_hp - damage;
                        end
                    end else if (i_overtime) begin
                        o_phase <= PH_DEFEND;
                    end
                end
                PH_DEFEND: begin
                    if (wait_cnt == WAIT_LAST) begin
                        o_phase  <= PH_MENU;
                        o_cursor <= CUR_FIGHT;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: o_phase <= PH_HOME;
            endcase
        end
    end

    // covers both moves inside the menu and the clear on entry
    a_cursor_in_menu: assert property (
        @(posedge clk) disable iff (cursor_position_rst)
        $changed(o_cursor) |-> o_phase == PH_MENU
    ) else $error("battle_fsm: cursor moved outside the menu");

endmodule

/* hdl/timing_bar.sv */
`timescale 1ns/10ps

module timing_bar
    import battle_pkg::*;
#(
    parameter int BAR_STEP_CYCLES = 1600000,
    parameter int BAR_VELOCITY    = 8,
    parameter int BAR_START_X     = 15
) (
    input  logic   clk,
    input  logic   cursor_position_rst,
    input  logic   i_restart,
    output coord_t o_bar_x,
    output logic   o_overtime
);

    localparam int STEP_W = $clog2(BAR_STEP_CYCLES + 1);
    localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(BAR_STEP_CYCLES - 1);

    logic [STEP_W-1:0] step_cnt;
    logic              parked;
    logic [16:0]       bar_next;

    // one extra bit so the off-screen check cannot wrap
    assign bar_next = {1'b0, o_bar_x} + 17'(BAR_VELOCITY);

    // bar sits still after reset and after overtime until restarted
    always_ff @(posedge clk) begin
        if (cursor_position_rst) begin
            o_bar_x    <= coord_t'(BAR_START_X);
            step_cnt   <= '0;
            parked     <= 1'b1;
            o_overtime <= 1'b0;
        end else begin
            o_overtime <= 1'b0;
            if (i_restart) begin
                o_bar_x  <= coord_t'(BAR_START_X);
                step_cnt <= '0;
                parked   <= 1'b0;
            end else if (!parked) begin
                if (step_cnt == STEP_LAST) begin
                    step_cnt <= '0;
                    if (bar_next > 17'(SCREEN_WIDTH)) begin
                        parked     <= 1'b1;
                        o_overtime <= 1'b1;
                    end else begin
                        o_bar_x <= bar_next[15:0];
                    end
                end else begin
                    step_cnt <= step_cnt + 1'b1;
                end
            end
        end
    end

    a_bar_on_screen: assert property (
        @(posedge clk) disable iff (cursor_position_rst)
        o_bar_x <= SCREEN_WIDTH
    ) else $error("timing_bar: bar beyond screen edge");

endmodule

/* hdl/key_decode.sv */
`timescale 1ns/10ps

module key_decode
    import battle_pkg::*;
(
    input  logic  clk,
    input  logic  cursor_position_rst,
    input  byte_t i_byte,
    input  logic  i_byte_valid,
    output key_t  o_keys,
    output byte_t o_echo,
    output logic  o_echo_send
);

    key_t keys_next;

    always_comb begin
        keys_next = '0;
        case (i_byte)
            KEY_ENTER: keys_next.enter = 1'b1;
            KEY_SPACE: keys_next.space = 1'b1;
            KEY_W:     keys_next.w     = 1'b1;
            KEY_A:     keys_next.a     = 1'b1;
            KEY_S:     keys_next.s     = 1'b1;
            KEY_D:     keys_next.d     = 1'b1;
            default:   keys_next       = '0;
        endcase
    end

    // strobes last exactly one cycle
    always_ff @(posedge clk) begin
        if (cursor_position_rst) begin
            o_keys      <= '0;
            o_echo_send <= 1'b0;
        end else begin
            o_keys      <= i_byte_valid ? keys_next : '0;
            o_echo_send <= i_byte_valid && (keys_next != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (i_byte_valid) begin
            o_echo <= i_byte;
        end
    end

    a_keys_onehot: assert property (
        @(posedge clk) disable iff (cursor_position_rst)
        $onehot0(o_keys)
    ) else $error("key_decode: more than one key strobe");

endmodule

/* hdl/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx
    import battle_pkg::*;
#(
    parameter int CLKS_PER_BIT = 434
) (
    input  logic  clk,
    input  logic  cursor_position_rst,
    input  logic  i_rx,
    output byte_t o_byte,
    output logic  o_byte_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic             rx_last;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    byte_t            shift_q;

    // line idles high
    always_ff @(posedge clk) begin
        if (cursor_position_rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (cursor_position_rst) begin
            state        <= RX_IDLE;
            clk_cnt      <= '0;
            bit_idx      <= '0;
            o_byte_valid <= 1'b0;
        end else begin
            o_byte_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (rx_last && !rx_sync) begin
                        state <= RX_START;
                    end
                end
                // glitch on the start bit falls back to idle
                RX_START: begin
                    if (clk_cnt == HALF_BIT) begin
                        clk_cnt <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt      <= '0;
                        state        <= RX_IDLE;
                        o_byte_valid <= rx_sync;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && clk_cnt == FULL_BIT) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
        if (state == RX_STOP && clk_cnt == FULL_BIT && rx_sync) begin
            o_byte <= shift_q;
        end
    end

endmodule

/* hdl/battle_pkg.sv */
package battle_pkg;

    //////////////////////////////////////////////////
    // game phase and key strobes
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        PH_HOME,
        PH_MENU,
        PH_ATTACK,
        PH_DEFEND
    } phase_t;

    // one strobe per recognized key, at most one high at a time
    typedef struct packed {
        logic enter;
        logic space;
        logic w;
        logic a;
        logic s;
        logic d;
    } key_t;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] coord_t;
    typedef logic [15:0] hp_t;

    // 0 is fight, 3 is mercy
    typedef logic [1:0]  cursor_t;

    // ascii codes of the keys
    localparam byte_t KEY_ENTER = 8'h0d;
    localparam byte_t KEY_SPACE = 8'h20;
    localparam byte_t KEY_W     = 8'h77;
    localparam byte_t KEY_A     = 8'h61;
    localparam byte_t KEY_S     = 8'h73;
    localparam byte_t KEY_D     = 8'h64;

    localparam coord_t SCREEN_WIDTH   = 16'd640;
    localparam hp_t    MONSTER_HP_MAX = 16'd200;

    //////////////////////////////////////////////////
    // score zones, nested, innermost first
    //////////////////////////////////////////////////

    localparam coord_t GREEN_LO   = 16'd305;
    localparam coord_t GREEN_HI   = 16'd325;
    localparam hp_t    GREEN_DMG  = 16'd100;
    localparam coord_t YELLOW_LO  = 16'd220;
    localparam coord_t YELLOW_HI  = 16'd395;
    localparam hp_t    YELLOW_DMG = 16'd50;
    localparam coord_t ORANGE_LO  = 16'd160;
    localparam coord_t ORANGE_HI  = 16'd455;
    localparam hp_t    ORANGE_DMG = 16'd10;
    localparam coord_t BLUE_LO    = 16'd115;
    localparam coord_t BLUE_HI    = 16'd500;
    localparam hp_t    BLUE_DMG   = 16'd5;

endpackage
